// File: wb_stream_params.svh
/*
 * wishbone stream bridge parameters
 * stream counts, queue depth and the register window base
 */

`ifndef WB_STREAM_PARAMS_SVH
`define WB_STREAM_PARAMS_SVH

// stream counts on each side
`define WB_NUM_ISTREAM 2
`define WB_NUM_OSTREAM 2

// words held per stream queue
`define WB_QUEUE_DEPTH 2

// first byte of the window, istreams sit here
`define WB_ISTREAM_BASE 32'h3000_0000

// index width covers the larger of the two stream counts, at least one bit
`define WB_MAX_STREAMS \
  ((`WB_NUM_ISTREAM > `WB_NUM_OSTREAM) ? `WB_NUM_ISTREAM : `WB_NUM_OSTREAM)
`define WB_STREAM_IDX_W (($clog2(`WB_MAX_STREAMS) > 0) ? $clog2(`WB_MAX_STREAMS) : 1)

`endif

// File: wb_stream_pkg.sv
/*
 * wishbone stream bridge types
 * decoded operation and the bus and stream request structs
 */

`default_nettype none

`include "wb_stream_params.svh"

package wb_stream_pkg;

  // decoded operation for one bus cycle
  typedef enum logic [2:0] {
    WB_OP_NONE           = 3'd0,
    WB_OP_ISTREAM_STATUS = 3'd1,
    WB_OP_ISTREAM_PUSH   = 3'd2,
    WB_OP_OSTREAM_STATUS = 3'd3,
    WB_OP_OSTREAM_POP    = 3'd4
  } wb_op_e;

  // slave side of one wishbone cycle
  typedef struct packed {
    logic        stb;
    logic        cyc;
    logic        we;
    // byte lanes, carried but not used
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_bus_req_t;

  // request after address decode
  typedef struct packed {
    wb_op_e                       op;
    logic [`WB_STREAM_IDX_W-1:0]  idx;
    logic [31:0]                  data;
  } wb_stream_req_t;

endpackage

`default_nettype wire

// File: wb_addr_decode.sv
/*
 * wishbone address decoder
 * maps a bus cycle onto a stream operation and stream index
 */

`default_nettype none

`include "wb_stream_params.svh"

module wb_addr_decode
  import wb_stream_pkg::*;
(
  input  logic           clk,
  input  wb_bus_req_t    wb_req_i,
  output wb_stream_req_t stream_req_o
);

  localparam logic [31:0] ISTREAM_BASE = `WB_ISTREAM_BASE;
  // ostreams follow the last istream, 8 bytes per stream
  localparam logic [31:0] OSTREAM_BASE = ISTREAM_BASE + 32'(`WB_NUM_ISTREAM * 8);
  localparam logic [31:0] WINDOW_END   = OSTREAM_BASE + 32'(`WB_NUM_OSTREAM * 8);

  logic        txn_val;
  logic        in_istream;
  logic        in_ostream;
  logic [31:0] offset;
  logic        aligned;

  assign txn_val    = wb_req_i.stb && wb_req_i.cyc;
  assign in_istream = (wb_req_i.adr >= ISTREAM_BASE) && (wb_req_i.adr < OSTREAM_BASE);
  assign in_ostream = (wb_req_i.adr >= OSTREAM_BASE) && (wb_req_i.adr < WINDOW_END);

  // offset from the base of whichever region was hit
  assign offset  = in_ostream ? (wb_req_i.adr - OSTREAM_BASE) : (wb_req_i.adr - ISTREAM_BASE);
  assign aligned = (offset[1:0] == 2'b00);

  ////////////////////////////////////////////////////////////////////////////
  // operation select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stream_req_o.op   = WB_OP_NONE;
    // stride of 8 bytes, index starts at bit 3
    stream_req_o.idx  = offset[3 +: `WB_STREAM_IDX_W];
    stream_req_o.data = wb_req_i.dat;

    if (txn_val && aligned) begin
      if (in_istream) begin
        // status is read only, data is write only
        if (!offset[2] && !wb_req_i.we) begin
          stream_req_o.op = WB_OP_ISTREAM_STATUS;
        end else if (offset[2] && wb_req_i.we) begin
          stream_req_o.op = WB_OP_ISTREAM_PUSH;
        end
      end else if (in_ostream && !wb_req_i.we) begin
        stream_req_o.op = offset[2] ? WB_OP_OSTREAM_POP : WB_OP_OSTREAM_STATUS;
      end
    end
  end

  // a push only ever comes from a bus write to the data word of a stream
  push_needs_we_a: assert property (
    @(posedge clk) (stream_req_o.op == WB_OP_ISTREAM_PUSH) |->
      (wb_req_i.we && (wb_req_i.adr[2:0] == 3'b100))
  );

endmodule

`default_nettype wire

// File: stream_queue.sv
/*
 * stream word queue
 * circular buffer with val/rdy on both sides and a free-entry count
 */

`default_nettype none

module stream_queue #(
  parameter int  DEPTH = 2,
  parameter int  WIDTH = 32,
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             reset_i,
  input  logic             enq_val_i,
  input  logic [WIDTH-1:0] enq_data_i,
  output logic             enq_rdy_o,
  output logic             deq_val_o,
  output logic [WIDTH-1:0] deq_data_o,
  input  logic             deq_rdy_i,
  output logic [CNT_W-1:0] free_entries_o
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr_next;
  logic [PTR_W-1:0] rd_ptr_next;
  logic [CNT_W-1:0] count;
  logic             enq_fire;
  logic             deq_fire;

  assign enq_rdy_o = (count < CNT_W'(DEPTH));
  assign deq_val_o = (count != '0);
  assign enq_fire  = enq_val_i && enq_rdy_o;
  assign deq_fire  = deq_val_o && deq_rdy_i;

  // pointers wrap at DEPTH, which need not be a power of two
  assign wr_ptr_next = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_ptr_next = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  assign deq_data_o     = mem[rd_ptr];
  assign free_entries_o = CNT_W'(DEPTH) - count;

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= wr_ptr_next;
      end
      if (deq_fire) begin
        rd_ptr <= rd_ptr_next;
      end
      // simultaneous enq and deq leave the count alone
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  count_bound_a: assert property (
    @(posedge clk) disable iff (reset_i) count <= CNT_W'(DEPTH)
  );

  // a full queue takes no word, so its head survives until it is read
  no_enq_when_full_a: assert property (
    @(posedge clk) disable iff (reset_i)
      (!enq_rdy_o && !deq_rdy_i) |=> $stable(deq_data_o)
  );

endmodule

`default_nettype wire

// File: wb_resp_select.sv
/*
 * wishbone response select
 * forms the read word and the ack from the decoded request
 */

`default_nettype none

`include "wb_stream_params.svh"

module wb_resp_select
  import wb_stream_pkg::*;
(
  input  wb_bus_req_t                          wb_req_i,
  input  wb_stream_req_t                       stream_req_i,
  input  logic [`WB_NUM_ISTREAM-1:0]           istream_space_i,
  input  logic [`WB_NUM_OSTREAM-1:0]           ostream_avail_i,
  input  logic [`WB_NUM_OSTREAM-1:0][31:0]     ostream_head_i,
  output logic                                 wb_ack_o,
  output logic [31:0]                          wb_dat_o
);

  // zero latency ack for every valid cycle
  assign wb_ack_o = wb_req_i.stb && wb_req_i.cyc;

  ////////////////////////////////////////////////////////////////////////////
  // read data mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (stream_req_i.op)
      WB_OP_ISTREAM_STATUS: begin
        wb_dat_o = {31'b0, istream_space_i[stream_req_i.idx]};
      end
      WB_OP_OSTREAM_STATUS: begin
        wb_dat_o = {31'b0, ostream_avail_i[stream_req_i.idx]};
      end
      WB_OP_OSTREAM_POP: begin
        // empty queue reads back as zero
        if (ostream_avail_i[stream_req_i.idx]) begin
          wb_dat_o = ostream_head_i[stream_req_i.idx];
        end else begin
          wb_dat_o = 32'b0;
        end
      end
      default: begin
        wb_dat_o = 32'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: wb_stream_bridge.sv
/*
 * wishbone stream bridge top
 * decoder, per-stream queues and response select
 */

`default_nettype none

`include "wb_stream_params.svh"

module wb_stream_bridge
  import wb_stream_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset_i,

  // wishbone slave
  input  wb_bus_req_t                          wb_req_i,
  output logic                                 wb_ack_o,
  output logic [31:0]                          wb_dat_o,

  // istreams, bridge is the producer
  output logic [`WB_NUM_ISTREAM-1:0]           istream_val_o,
  output logic [`WB_NUM_ISTREAM-1:0][31:0]     istream_data_o,
  input  logic [`WB_NUM_ISTREAM-1:0]           istream_rdy_i,

  // ostreams, bridge is the consumer
  input  logic [`WB_NUM_OSTREAM-1:0]           ostream_val_i,
  input  logic [`WB_NUM_OSTREAM-1:0][31:0]     ostream_data_i,
  output logic [`WB_NUM_OSTREAM-1:0]           ostream_rdy_o
);

  wb_stream_req_t                      stream_req;
  logic [`WB_NUM_ISTREAM-1:0]          istream_push;
  logic [`WB_NUM_ISTREAM-1:0]          istream_space;
  logic [`WB_NUM_OSTREAM-1:0]          ostream_pop;
  logic [`WB_NUM_OSTREAM-1:0]          ostream_avail;
  logic [`WB_NUM_OSTREAM-1:0][31:0]    ostream_head;

  wb_addr_decode addr_decode_i (
    .clk          (clk),
    .wb_req_i     (wb_req_i),
    .stream_req_o (stream_req)
  );

  ////////////////////////////////////////////////////////////////////////////
  // istream queues, filled by bus writes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < `WB_NUM_ISTREAM; n++) begin : g_istream
    assign istream_push[n] = (stream_req.op == WB_OP_ISTREAM_PUSH) && (stream_req.idx == n);

    stream_queue #(
      .DEPTH (`WB_QUEUE_DEPTH),
      .WIDTH (32)
    ) istream_queue_i (
      .clk            (clk),
      .reset_i        (reset_i),
      .enq_val_i      (istream_push[n]),
      .enq_data_i     (stream_req.data),
      .enq_rdy_o      (istream_space[n]),
      .deq_val_o      (istream_val_o[n]),
      .deq_data_o     (istream_data_o[n]),
      .deq_rdy_i      (istream_rdy_i[n]),
      .free_entries_o ()
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // ostream queues, drained by bus reads
  ////////////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < `WB_NUM_OSTREAM; n++) begin : g_ostream
    assign ostream_pop[n] = (stream_req.op == WB_OP_OSTREAM_POP) && (stream_req.idx == n);

    stream_queue #(
      .DEPTH (`WB_QUEUE_DEPTH),
      .WIDTH (32)
    ) ostream_queue_i (
      .clk            (clk),
      .reset_i        (reset_i),
      .enq_val_i      (ostream_val_i[n]),
      .enq_data_i     (ostream_data_i[n]),
      .enq_rdy_o      (ostream_rdy_o[n]),
      .deq_val_o      (ostream_avail[n]),
      .deq_data_o     (ostream_head[n]),
      .deq_rdy_i      (ostream_pop[n]),
      .free_entries_o ()
    );
  end

  wb_resp_select resp_select_i (
    .wb_req_i        (wb_req_i),
    .stream_req_i    (stream_req),
    .istream_space_i (istream_space),
    .ostream_avail_i (ostream_avail),
    .ostream_head_i  (ostream_head),
    .wb_ack_o        (wb_ack_o),
    .wb_dat_o        (wb_dat_o)
  );

endmodule

`default_nettype wire

// File: tb_wb_stream_bridge.sv
/*
 * wishbone stream bridge testbench
 * table of bus steps with istream and ostream models
 */

`default_nettype none

`include "wb_stream_params.svh"

module tb_wb_stream_bridge
  import wb_stream_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NI = `WB_NUM_ISTREAM;
  localparam int NO = `WB_NUM_OSTREAM;
  localparam int RESET_CYCLES = 8;

  // register map, 8 bytes per stream, ostreams right after the istreams
  localparam logic [31:0] BASE    = `WB_ISTREAM_BASE;
  localparam logic [31:0] OBASE   = BASE + 32'(NI * 8);
  localparam logic [31:0] WEND    = OBASE + 32'(NO * 8);
  localparam logic [31:0] I0_STAT = BASE;
  localparam logic [31:0] I0_PUSH = BASE + 32'h4;
  localparam logic [31:0] I1_STAT = BASE + 32'h8;
  localparam logic [31:0] I1_PUSH = BASE + 32'hc;
  localparam logic [31:0] O0_STAT = OBASE;
  localparam logic [31:0] O0_POP  = OBASE + 32'h4;
  localparam logic [31:0] O1_STAT = OBASE + 32'h8;
  localparam logic [31:0] O1_POP  = OBASE + 32'hc;

  localparam logic [31:0] WA1 = 32'ha000_0001;
  localparam logic [31:0] WA2 = 32'ha000_0002;
  localparam logic [31:0] WA3 = 32'ha000_0003;
  localparam logic [31:0] WB1 = 32'hb000_0001;

  // one table row, istream expectations hold one cycle after the step
  typedef struct packed {
    wb_bus_req_t           req;
    logic [NO-1:0]         o_val;
    logic [NI-1:0]         i_rdy;
    logic [31:0]           exp_dat;
    logic                  from_model;
    logic [NI-1:0]         exp_ival;
    logic [NI-1:0][31:0]   exp_idata;
  } step_t;

  logic                  clk;
  logic                  reset_i;
  wb_bus_req_t           wb_req_i;
  logic                  wb_ack_o;
  logic [31:0]           wb_dat_o;
  logic [NI-1:0]         istream_val_o;
  logic [NI-1:0][31:0]   istream_data_o;
  logic [NI-1:0]         istream_rdy_i;
  logic [NO-1:0]         ostream_val_i;
  logic [NO-1:0][31:0]   ostream_data_i;
  logic [NO-1:0]         ostream_rdy_o;

  step_t       steps[$];
  logic [31:0] model_q[NO][$];
  int          seed = 6;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  wb_stream_bridge dut_i (
    .clk            (clk),
    .reset_i        (reset_i),
    .wb_req_i       (wb_req_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .istream_val_o  (istream_val_o),
    .istream_data_o (istream_data_o),
    .istream_rdy_i  (istream_rdy_i),
    .ostream_val_i  (ostream_val_i),
    .ostream_data_i (ostream_data_i),
    .ostream_rdy_o  (ostream_rdy_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // request builders and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic wb_bus_req_t bus_cycle(input logic stb, input logic cyc, input logic we,
                                            input logic [31:0] adr, input logic [31:0] dat);
    wb_bus_req_t r;
    r.stb = stb;
    r.cyc = cyc;
    r.we  = we;
    r.sel = 4'hf;
    r.adr = adr;
    r.dat = dat;
    return r;
  endfunction

  function automatic wb_bus_req_t bus_read(input logic [31:0] adr);
    return bus_cycle(1'b1, 1'b1, 1'b0, adr, 32'h0);
  endfunction

  function automatic wb_bus_req_t bus_write(input logic [31:0] adr, input logic [31:0] dat);
    return bus_cycle(1'b1, 1'b1, 1'b1, adr, dat);
  endfunction

  task automatic add_step(input wb_bus_req_t req, input logic [NO-1:0] o_val,
                          input logic [NI-1:0] i_rdy, input logic [31:0] exp_dat,
                          input logic from_model, input logic [NI-1:0] exp_ival,
                          input logic [NI-1:0][31:0] exp_idata);
    step_t s;
    s.req        = req;
    s.o_val      = o_val;
    s.i_rdy      = i_rdy;
    s.exp_dat    = exp_dat;
    s.from_model = from_model;
    s.exp_ival   = exp_ival;
    s.exp_idata  = exp_idata;
    steps.push_back(s);
  endtask

  task automatic check_bus_data(input string name, input logic [31:0] exp_v,
                                input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Fail at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  // data only matters while val is expected high
  task automatic check_stream(input string name, input logic exp_val, input logic [31:0] exp_data,
                              input logic act_val, input logic [31:0] act_data);
    check_flag({name, "_val"}, exp_val, act_val);
    if (exp_val) begin
      check_bus_data({name, "_data"}, exp_data, act_data);
    end
  endtask

  task automatic drive_step(input step_t s);
    wb_req_i      <= s.req;
    istream_rdy_i <= s.i_rdy;
    ostream_val_i <= s.o_val;
    for (int n = 0; n < NO; n++) begin
      ostream_data_i[n] <= $random(seed);
    end
  endtask

  task automatic check_istreams(input step_t s);
    for (int n = 0; n < NI; n++) begin
      check_stream($sformatf("istream_%0d", n), s.exp_ival[n], s.exp_idata[n],
                   istream_val_o[n], istream_data_o[n]);
    end
  endtask

  task automatic build_table();
    // reset state, then istream push, hold and full
    add_step(bus_read(I0_STAT), 2'b00, 2'b00, 32'h1, 1'b0, 2'b00, '0);
    add_step(bus_read(I1_STAT), 2'b00, 2'b00, 32'h1, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_STAT), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(O1_STAT), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_write(I0_PUSH, WA1), 2'b00, 2'b00, 32'h0, 1'b0, 2'b01, {32'h0, WA1});
    add_step(bus_write(I0_PUSH, WA2), 2'b00, 2'b00, 32'h0, 1'b0, 2'b01, {32'h0, WA1});
    add_step(bus_read(I0_STAT), 2'b00, 2'b00, 32'h0, 1'b0, 2'b01, {32'h0, WA1});
    add_step(bus_write(I0_PUSH, WA3), 2'b00, 2'b00, 32'h0, 1'b0, 2'b01, {32'h0, WA1});
    add_step(bus_write(I1_PUSH, WB1), 2'b00, 2'b00, 32'h0, 1'b0, 2'b11, {WB1, WA1});
    add_step(bus_cycle(0, 0, 0, 0, 0), 2'b00, 2'b01, 32'h0, 1'b0, 2'b11, {WB1, WA2});
    add_step(bus_read(I0_STAT), 2'b00, 2'b01, 32'h1, 1'b0, 2'b10, {WB1, 32'h0});
    add_step(bus_cycle(0, 0, 0, 0, 0), 2'b00, 2'b11, 32'h0, 1'b0, 2'b00, '0);
    // ostream status and pops, the queue of stream 0 fills up
    add_step(bus_read(I0_STAT), 2'b01, 2'b00, 32'h1, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_STAT), 2'b01, 2'b00, 32'h1, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_STAT), 2'b01, 2'b00, 32'h1, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_POP), 2'b00, 2'b00, 32'h0, 1'b1, 2'b00, '0);
    add_step(bus_read(O1_STAT), 2'b10, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(O1_POP), 2'b00, 2'b00, 32'h0, 1'b1, 2'b00, '0);
    add_step(bus_read(O0_POP), 2'b01, 2'b00, 32'h0, 1'b1, 2'b00, '0);
    add_step(bus_read(O0_POP), 2'b00, 2'b00, 32'h0, 1'b1, 2'b00, '0);
    add_step(bus_read(O0_STAT), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_POP), 2'b00, 2'b00, 32'h0, 1'b1, 2'b00, '0);
    add_step(bus_read(O1_STAT), 2'b01, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    // unmapped, misaligned and partial cycles leave the queues alone
    add_step(bus_read(O0_POP + 32'h1), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_POP + 32'h2), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_POP + 32'h3), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(I0_PUSH), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(WEND + 32'h4), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(BASE - 32'h4), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_write(O0_POP, 32'h1), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_write(I0_PUSH + 32'h1, WA3), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_cycle(1, 0, 0, O0_POP, 0), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_cycle(0, 1, 0, O0_POP, 0), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(O0_POP), 2'b00, 2'b00, 32'h0, 1'b1, 2'b00, '0);
    add_step(bus_read(O0_STAT), 2'b00, 2'b00, 32'h0, 1'b0, 2'b00, '0);
    add_step(bus_read(I0_STAT), 2'b00, 2'b00, 32'h1, 1'b0, 2'b00, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]   exp_dat;
    logic [NO-1:0] exp_rdy;
    int            n;

    reset_i        = 1'b1;
    wb_req_i       = bus_cycle(0, 0, 0, 0, 0);
    istream_rdy_i  = '0;
    ostream_val_i  = '0;
    ostream_data_i = '0;
    build_table();
    cycle_limit = 2 * steps.size() + RESET_CYCLES;

    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    for (int k = 0; k < NI; k++) begin
      check_flag($sformatf("istream_val_o[%0d]", k), 1'b0, istream_val_o[k]);
    end
    for (int k = 0; k < NO; k++) begin
      check_flag($sformatf("ostream_rdy_o[%0d]", k), 1'b1, ostream_rdy_o[k]);
    end

    foreach (steps[i]) begin
      @(posedge clk);
      drive_step(steps[i]);
      @(negedge clk);
      check_flag("wb_ack_o", steps[i].req.stb && steps[i].req.cyc, wb_ack_o);
      // an ostream queue has room while the model holds fewer than depth words
      for (int k = 0; k < NO; k++) begin
        exp_rdy[k] = (model_q[k].size() < `WB_QUEUE_DEPTH);
        check_flag($sformatf("ostream_rdy_o[%0d]", k), exp_rdy[k], ostream_rdy_o[k]);
      end
      exp_dat = steps[i].exp_dat;
      // pops expect the oldest word the producer handed over
      if (steps[i].from_model) begin
        n = int'((steps[i].req.adr - OBASE) >> 3);
        exp_dat = (model_q[n].size() > 0) ? model_q[n].pop_front() : 32'h0;
      end
      check_bus_data("wb_dat_o", exp_dat, wb_dat_o);
      if (i > 0) begin
        check_istreams(steps[i-1]);
      end
      // words the ostream queues take at the coming edge
      for (int k = 0; k < NO; k++) begin
        if (ostream_val_i[k] && exp_rdy[k]) begin
          model_q[k].push_back(ostream_data_i[k]);
        end
      end
    end

    @(posedge clk);
    drive_step(step_t'(0));
    @(negedge clk);
    check_istreams(steps[steps.size()-1]);

    $display("run complete, %0d steps, %0d errors", steps.size(), errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog on clock cycles
  initial begin
    @(posedge clk);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
wb_stream_pkg.sv
wb_addr_decode.sv
stream_queue.sv
wb_resp_select.sv
wb_stream_bridge.sv
tb_wb_stream_bridge.sv
